// File: Bender.yml
package:
  name: mem_io_access

sources:
  - src/memIoPkg.sv
  - src/accessDecode.sv
  - src/dataMem.sv
  - src/ioPorts.sv
  - src/segDisplayQueue.sv
  - src/responseStage.sv
  - src/memIoTop.sv
  - target: test
    files:
      - verif/memIoTb.sv

// File: src/accessDecode.sv
`timescale 1ns/1ps

module accessDecode (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  reqValid,
  input  memIoPkg::memReqT      req,
  output logic                  reqReady,
  output logic                  decValid,
  output memIoPkg::decodedReqT  dec,
  input  logic                  decReady
);

  memIoPkg::decodedReqT decNext;
  logic                 accept;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    decNext.op      = req.op;
    decNext.wdata   = req.wdata;
    // Word index from the byte address, bits 11:2
    decNext.wordIdx = req.addr[memIoPkg::dmemAddrBits+1:2];
    if (req.addr >= memIoPkg::ioBase) begin
      // I/O region
      case (req.addr)
        memIoPkg::ioSegAddr:   decNext.target = memIoPkg::tgtSeg;
        memIoPkg::ioLedAddr:   decNext.target = memIoPkg::tgtLed;
        memIoPkg::ioBlinkAddr: decNext.target = memIoPkg::tgtBlink;
        memIoPkg::ioSwAAddr:   decNext.target = memIoPkg::tgtSwA;
        memIoPkg::ioSwBAddr:   decNext.target = memIoPkg::tgtSwB;
        memIoPkg::ioTestAddr:  decNext.target = memIoPkg::tgtTest;
        // Unmapped I/O word
        default:               decNext.target = memIoPkg::tgtNone;
      endcase
    end else begin
      decNext.target = memIoPkg::tgtDmem;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Holding register
  ////////////////////////////////////////////////////////////////////////////

  // Room when empty or when the held entry moves on this cycle
  assign reqReady = !decValid || decReady;
  assign accept   = reqValid && reqReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decValid <= 1'b0;
    end else if (accept) begin
      decValid <= 1'b1;
    end else if (decReady) begin
      decValid <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      dec <= decNext;
    end
  end

endmodule

// File: src/dataMem.sv
`timescale 1ns/1ps

module dataMem (
  input  logic                              clk,
  input  logic                              rdEn,
  input  logic                              wrEn,
  input  logic [memIoPkg::dmemAddrBits-1:0] wordIdx,
  input  logic [31:0]                       wdata,
  output logic [31:0]                       rdata
);

  // Word array
  logic [31:0] mem [memIoPkg::dmemWords];

  // Write port
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wordIdx] <= wdata;
    end
  end

  // Registered read
  // Holds the last word while rdEn is low
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rdata <= mem[wordIdx];
    end
  end

endmodule

// File: src/ioPorts.sv
`timescale 1ns/1ps

module ioPorts (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          advance,
  input  memIoPkg::decodedReqT          dec,
  input  logic [7:0]                    switchIn,
  input  logic                          enterA,
  input  logic                          enterB,
  input  logic [2:0]                    testIn,
  output logic [memIoPkg::segWidth-1:0] ledOut,
  output logic                          blinkOut,
  output logic [31:0]                   ioRdata
);

  // Switch entry registers
  logic [7:0]  swA;
  logic [7:0]  swB;
  // Blink down-counter
  logic [31:0] blinkCnt;
  // Store and load strobes for this advance
  logic        storeHit;
  logic        loadHit;
  logic [31:0] rdSel;

  assign storeHit = advance && (dec.op == memIoPkg::opStore);
  assign loadHit  = advance && (dec.op == memIoPkg::opLoad);

  ////////////////////////////////////////////////////////////////////////////
  // Switches
  ////////////////////////////////////////////////////////////////////////////

  // Captured on the edge where the enter key is seen
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      swA <= '0;
      swB <= '0;
    end else begin
      if (enterA) begin
        swA <= switchIn;
      end
      if (enterB) begin
        swB <= switchIn;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // LED and blink timer
  ////////////////////////////////////////////////////////////////////////////

  // LED keeps the low bits of the stored word
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ledOut <= '0;
    end else if (storeHit && (dec.target == memIoPkg::tgtLed)) begin
      ledOut <= dec.wdata[memIoPkg::segWidth-1:0];
    end
  end

  // Load with the count, then run down to zero
  // a new store restarts it
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      blinkCnt <= '0;
    end else if (storeHit && (dec.target == memIoPkg::tgtBlink)) begin
      blinkCnt <= dec.wdata;
    end else if (blinkCnt != '0) begin
      blinkCnt <= blinkCnt - 32'd1;
    end
  end

  // High for exactly the loaded number of cycles
  assign blinkOut = (blinkCnt != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////////////////////

  // Zero-extended port values
  always_comb begin
    case (dec.target)
      memIoPkg::tgtSwA:  rdSel = {24'd0, swA};
      memIoPkg::tgtSwB:  rdSel = {24'd0, swB};
      memIoPkg::tgtTest: rdSel = {29'd0, testIn};
      memIoPkg::tgtLed:  rdSel = {{(32 - memIoPkg::segWidth){1'b0}}, ledOut};
      // Seg, blink, unmapped and memory read as zero here
      default:           rdSel = '0;
    endcase
  end

  // Registered so it lines up with the memory read port
  always_ff @(posedge clk) begin
    if (loadHit) begin
      ioRdata <= rdSel;
    end
  end

endmodule

// File: src/memIoPkg.sv
package memIoPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  // Word-addressed data memory
  localparam int dmemWords    = 1024;
  localparam int dmemAddrBits = 10;

  // Everything at or above the base goes to the I/O ports
  localparam logic [31:0] ioBase = 32'hFFFF_FC00;

  // Mapped I/O words
  localparam logic [31:0] ioSegAddr   = ioBase + 32'h00;
  localparam logic [31:0] ioLedAddr   = ioBase + 32'h04;
  localparam logic [31:0] ioBlinkAddr = ioBase + 32'h08;
  localparam logic [31:0] ioSwAAddr   = ioBase + 32'h10;
  localparam logic [31:0] ioSwBAddr   = ioBase + 32'h14;
  localparam logic [31:0] ioTestAddr  = ioBase + 32'h18;

  ////////////////////////////////////////////////////////////////////////////
  // Display and LED sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int segQueueDepth = 32;
  localparam int segPtrBits    = $clog2(segQueueDepth);
  // Default display time per queue entry, in cycles
  localparam int segHoldCycles = 8;
  localparam int segWidth      = 24;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    opLoad,
    opStore
  } memOpE;

  // Where a decoded access lands
  typedef enum logic [2:0] {
    tgtDmem,
    tgtSeg,
    tgtLed,
    tgtBlink,
    tgtSwA,
    tgtSwB,
    tgtTest,
    tgtNone
  } ioTargetE;

  // Request as issued by the core
  typedef struct packed {
    memOpE       op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } memReqT;

  // Request after address decode
  typedef struct packed {
    memOpE                   op;
    ioTargetE                target;
    logic [dmemAddrBits-1:0] wordIdx;
    logic [31:0]             wdata;
  } decodedReqT;

  // One response per request, loads and stores alike
  typedef struct packed {
    memOpE       op;
    logic [31:0] rdata;
  } memRespT;

endpackage

// File: src/memIoTop.sv
`timescale 1ns/1ps

module memIoTop (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          reqValid,
  input  memIoPkg::memReqT              req,
  output logic                          reqReady,
  output logic                          respValid,
  output memIoPkg::memRespT             resp,
  input  logic                          respReady,
  input  logic [7:0]                    switchIn,
  input  logic                          enterA,
  input  logic                          enterB,
  input  logic [2:0]                    testIn,
  output logic [memIoPkg::segWidth-1:0] segOut,
  output logic [memIoPkg::segWidth-1:0] ledOut,
  output logic                          blinkOut
);

  // Stage one to stage two
  logic                 decValid;
  logic                 decReady;
  memIoPkg::decodedReqT dec;
  logic                 advance;
  // Read data sources
  logic [31:0]          memRdata;
  logic [31:0]          ioRdata;
  // Side effects of an advancing access
  logic                 dmemRd;
  logic                 dmemWr;
  logic                 segPush;

  assign advance = decValid && decReady;
  assign dmemRd  = advance && (dec.target == memIoPkg::tgtDmem) && (dec.op == memIoPkg::opLoad);
  assign dmemWr  = advance && (dec.target == memIoPkg::tgtDmem) && (dec.op == memIoPkg::opStore);
  assign segPush = advance && (dec.target == memIoPkg::tgtSeg) && (dec.op == memIoPkg::opStore);

  accessDecode decode_i (
    .clk      (clk),
    .arstN    (arstN),
    .reqValid (reqValid),
    .req      (req),
    .reqReady (reqReady),
    .decValid (decValid),
    .dec      (dec),
    .decReady (decReady)
  );

  dataMem dmem_i (
    .clk     (clk),
    .rdEn    (dmemRd),
    .wrEn    (dmemWr),
    .wordIdx (dec.wordIdx),
    .wdata   (dec.wdata),
    .rdata   (memRdata)
  );

  ioPorts io_i (
    .clk      (clk),
    .arstN    (arstN),
    .advance  (advance),
    .dec      (dec),
    .switchIn (switchIn),
    .enterA   (enterA),
    .enterB   (enterB),
    .testIn   (testIn),
    .ledOut   (ledOut),
    .blinkOut (blinkOut),
    .ioRdata  (ioRdata)
  );

  segDisplayQueue #(
    .holdCycles (memIoPkg::segHoldCycles)
  ) seg_i (
    .clk      (clk),
    .arstN    (arstN),
    .push     (segPush),
    .pushData (dec.wdata[memIoPkg::segWidth-1:0]),
    .segOut   (segOut)
  );

  responseStage resp_i (
    .clk       (clk),
    .arstN     (arstN),
    .advance   (advance),
    .dec       (dec),
    .decReady  (decReady),
    .memRdata  (memRdata),
    .ioRdata   (ioRdata),
    .respValid (respValid),
    .resp      (resp),
    .respReady (respReady)
  );

endmodule

// File: src/responseStage.sv
`timescale 1ns/1ps

module responseStage (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 advance,
  input  memIoPkg::decodedReqT dec,
  output logic                 decReady,
  input  logic [31:0]          memRdata,
  input  logic [31:0]          ioRdata,
  output logic                 respValid,
  output memIoPkg::memRespT    resp,
  input  logic                 respReady
);

  // Registered op and target of the response in flight
  memIoPkg::memOpE    opQ;
  memIoPkg::ioTargetE tgtQ;

  // Empty or draining this cycle
  assign decReady = !respValid || respReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respValid <= 1'b0;
    end else if (advance) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      opQ  <= dec.op;
      tgtQ <= dec.target;
    end
  end

  // Read data merge
  // Both sources hold their value while stalled
  always_comb begin
    resp.op = opQ;
    if (opQ == memIoPkg::opStore) begin
      resp.rdata = '0;
    end else if (tgtQ == memIoPkg::tgtDmem) begin
      resp.rdata = memRdata;
    end else begin
      resp.rdata = ioRdata;
    end
  end

endmodule

// File: src/segDisplayQueue.sv
`timescale 1ns/1ps

module segDisplayQueue #(
  parameter int holdCycles = memIoPkg::segHoldCycles
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          push,
  input  logic [memIoPkg::segWidth-1:0] pushData,
  output logic [memIoPkg::segWidth-1:0] segOut
);

  // Entry storage
  logic [memIoPkg::segWidth-1:0]   entries [memIoPkg::segQueueDepth];
  // Pointers wrap naturally since depth is a power of two
  logic [memIoPkg::segPtrBits-1:0] head;
  logic [memIoPkg::segPtrBits-1:0] tail;
  logic [memIoPkg::segPtrBits:0]   count;
  // Cycles the head entry has been shown
  logic [$clog2(holdCycles+1)-1:0] holdCnt;

  logic full;
  logic empty;
  logic pushOk;
  logic pop;

  assign full  = (count == memIoPkg::segQueueDepth);
  assign empty = (count == '0);
  // Full queue drops the push even if a pop happens on the same edge
  assign pushOk = push && !full;
  // Head leaves after its last display cycle
  assign pop    = !empty && (holdCnt == ($bits(holdCnt))'(holdCycles - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (pushOk) begin
      entries[tail] <= pushData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      head    <= '0;
      tail    <= '0;
      count   <= '0;
      holdCnt <= '0;
    end else begin
      if (pushOk) begin
        tail <= tail + 1'b1;
      end
      // Hold timer runs only while something is shown
      if (pop) begin
        head    <= head + 1'b1;
        holdCnt <= '0;
      end else if (!empty) begin
        holdCnt <= holdCnt + 1'b1;
      end
      // Occupancy
      case ({pushOk, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Blank display when nothing is queued
  assign segOut = empty ? '0 : entries[head];

endmodule

// File: verif/memIoTb.sv
`timescale 1ns/1ps

module memIoTb;

  localparam logic [1:0] swKeep   = 2'd0;
  localparam logic [1:0] swEnterA = 2'd1;
  localparam logic [1:0] swEnterB = 2'd2;
  localparam int waitLimit = 1000;

  // One stimulus row with its expected read data
  typedef struct packed {
    memIoPkg::memOpE op;
    logic [31:0]     addr;
    logic [31:0]     wdata;
    logic [1:0]      swAct;
    logic [7:0]      swVal;
    logic            chk;
    logic [31:0]     rdata;
  } stimT;

  // Scoreboard entry, one per accepted request
  typedef struct packed {
    logic            chk;
    memIoPkg::memOpE op;
    logic [31:0]     rdata;
    logic [31:0]     cyc;
  } expT;

  // Segment push and the edge it lands on
  typedef struct packed {
    logic [memIoPkg::segWidth-1:0] data;
    logic [31:0]                   due;
  } segPushT;

  logic                          clk;
  logic                          arstN;
  logic                          reqValid;
  memIoPkg::memReqT              req;
  logic                          reqReady;
  logic                          respValid;
  memIoPkg::memRespT             resp;
  logic                          respReady;
  logic [7:0]                    switchIn;
  logic                          enterA;
  logic                          enterB;
  logic [2:0]                    testIn;
  logic [memIoPkg::segWidth-1:0] segOut;
  logic [memIoPkg::segWidth-1:0] ledOut;
  logic                          blinkOut;

  // Stimulus table and scoreboard
  stimT                          tbl [$];
  stimT                          curEntry;
  expT                           expQ [$];
  segPushT                       segPend [$];
  logic [memIoPkg::segWidth-1:0] segQ [$];
  int                            segHold;
  // Pushes the model turned away because the queue was full
  int                            segDrops;
  logic                          acceptSeen;
  logic                          stallMode;
  logic                          latencyChk;
  logic [31:0]                   cycle;
  int                            blinkHigh;
  int                            errors;

  // Reference copies of the memory and the I/O registers
  logic [31:0]                   mdlMem [int];
  logic [7:0]                    mdlSwA;
  logic [7:0]                    mdlSwB;
  logic [memIoPkg::segWidth-1:0] mdlLed;

  memIoTop dut_i (
    .clk       (clk),
    .arstN     (arstN),
    .reqValid  (reqValid),
    .req       (req),
    .reqReady  (reqReady),
    .respValid (respValid),
    .resp      (resp),
    .respReady (respReady),
    .switchIn  (switchIn),
    .enterA    (enterA),
    .enterB    (enterB),
    .testIn    (testIn),
    .segOut    (segOut),
    .ledOut    (ledOut),
    .blinkOut  (blinkOut)
  );

  always #2 clk = ~clk;

  // Random back-pressure while stalls are enabled
  always @(negedge clk) begin
    if (stallMode) begin
      respReady = ($urandom % 3) != 0;
    end else begin
      respReady = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic void addEntry(input memIoPkg::memOpE op, input logic [31:0] addr,
                                   input logic [31:0] wdata, input logic [1:0] swAct,
                                   input logic [7:0] swVal);
    stimT e;
    int   idx;
    e     = '{op: op, addr: addr, wdata: wdata, swAct: swAct, swVal: swVal,
              chk: 1'b1, rdata: 32'd0};
    idx   = int'(addr[11:2]);
    // Switch key is seen before the access reaches the ports
    if (swAct == swEnterA) mdlSwA = swVal;
    if (swAct == swEnterB) mdlSwB = swVal;
    if (addr < memIoPkg::ioBase) begin
      if (op == memIoPkg::opStore) begin
        mdlMem[idx] = wdata;
      end else if (mdlMem.exists(idx)) begin
        e.rdata = mdlMem[idx];
      end else begin
        // Never written, value unknown
        e.chk = 1'b0;
      end
    end else if (op == memIoPkg::opStore) begin
      if (addr == memIoPkg::ioLedAddr) mdlLed = wdata[memIoPkg::segWidth-1:0];
    end else begin
      case (addr)
        memIoPkg::ioSwAAddr:  e.rdata = {24'd0, mdlSwA};
        memIoPkg::ioSwBAddr:  e.rdata = {24'd0, mdlSwB};
        memIoPkg::ioTestAddr: e.rdata = {29'd0, testIn};
        memIoPkg::ioLedAddr:  e.rdata = {8'd0, mdlLed};
        default:              e.rdata = 32'd0;
      endcase
    end
    tbl.push_back(e);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    expT                           got;
    segPushT                       sp;
    logic [memIoPkg::segWidth-1:0] expSeg;
    logic                          popNow;
    logic                          fullNow;
    memIoPkg::memRespT             heldResp;
    logic                          holdPrev;
    if (!arstN) begin
      holdPrev = 1'b0;
    end else begin
      cycle = cycle + 1;
      // Stalled response must not move or change
      if (holdPrev && (!respValid || resp !== heldResp)) begin
        $display("mismatch at %0t: response changed under back-pressure", $time);
        errors++;
      end
      holdPrev = respValid && !respReady;
      heldResp = resp;
      if (respValid && respReady) begin
        if (expQ.size() == 0) begin
          $display("Response arrived with no request outstanding at %0t", $time);
          errors++;
        end else begin
          got = expQ.pop_front();
          if (resp.op !== got.op) begin
            $display("mismatch at %0t: op %0d, expected %0d", $time, resp.op, got.op);
            errors++;
          end
          if (got.chk && resp.rdata !== got.rdata) begin
            $display("mismatch at %0t: rdata %h, expected %h", $time, resp.rdata, got.rdata);
            errors++;
          end
          if (latencyChk && (cycle - got.cyc) != 32'd2) begin
            $display("mismatch at %0t: latency %0d edges", $time, cycle - got.cyc);
            errors++;
          end
        end
      end
      // Record the accepted request after the response check
      if (reqValid && reqReady) begin
        expQ.push_back('{chk: curEntry.chk, op: req.op, rdata: curEntry.rdata, cyc: cycle});
        acceptSeen = 1'b1;
        if (req.op == memIoPkg::opStore && req.addr == memIoPkg::ioSegAddr) begin
          // Push lands on the advance edge, one after acceptance
          segPend.push_back('{data: req.wdata[memIoPkg::segWidth-1:0], due: cycle + 1});
        end
      end
      // Display queue, same pop timing as the hold rule
      expSeg = (segQ.size() == 0) ? '0 : segQ[0];
      if (segOut !== expSeg) begin
        $display("mismatch at %0t: segOut %h, expected %h", $time, segOut, expSeg);
        errors++;
      end
      popNow  = (segQ.size() != 0) && (segHold == memIoPkg::segHoldCycles - 1);
      fullNow = (segQ.size() == memIoPkg::segQueueDepth);
      if (popNow) begin
        void'(segQ.pop_front());
        segHold = 0;
      end else if (segQ.size() != 0) begin
        segHold++;
      end
      if (segPend.size() != 0 && segPend[0].due == cycle) begin
        sp = segPend.pop_front();
        if (!fullNow) begin
          segQ.push_back(sp.data);
        end else begin
          segDrops++;
        end
      end
      if (blinkOut) blinkHigh++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic finishRun();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic driveEntry(input stimT e);
    int waitCnt;
    curEntry   = e;
    req.op     = e.op;
    req.addr   = e.addr;
    req.wdata  = e.wdata;
    reqValid   = 1'b1;
    switchIn   = e.swVal;
    enterA     = (e.swAct == swEnterA);
    enterB     = (e.swAct == swEnterB);
    acceptSeen = 1'b0;
    waitCnt    = 0;
    do begin
      @(negedge clk);
      waitCnt++;
      if (waitCnt > waitLimit) begin
        $display("Timeout: request to %h was never accepted", e.addr);
        errors++;
        finishRun();
      end
    end while (!acceptSeen);
  endtask

  // Apply the whole table back-to-back, then wait for every response
  task automatic runTable();
    int waitCnt;
    foreach (tbl[i]) driveEntry(tbl[i]);
    reqValid = 1'b0;
    enterA   = 1'b0;
    enterB   = 1'b0;
    waitCnt  = 0;
    while (expQ.size() != 0 || respValid) begin
      @(negedge clk);
      waitCnt++;
      if (waitCnt > waitLimit) begin
        $display("Timeout: %0d responses still missing", expQ.size());
        errors++;
        finishRun();
      end
    end
    tbl.delete();
  endtask

  task automatic waitSegEmpty();
    int waitCnt;
    waitCnt = 0;
    while (segQ.size() != 0 || segPend.size() != 0) begin
      @(negedge clk);
      waitCnt++;
      if (waitCnt > waitLimit) begin
        $display("Timeout: display queue never drained");
        errors++;
        finishRun();
      end
    end
  endtask

  task automatic checkBlink(input logic [31:0] n);
    addEntry(memIoPkg::opStore, memIoPkg::ioBlinkAddr, n, swKeep, 8'd0);
    blinkHigh = 0;
    runTable();
    // Window long enough for the whole pulse
    repeat (n + 10) @(negedge clk);
    if (blinkHigh != n) begin
      $display("mismatch at %0t: blink high %0d cycles, expected %0d", $time, blinkHigh, n);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] addrs [6];
    void'($urandom(1));
    clk        = 1'b0;
    arstN      = 1'b0;
    reqValid   = 1'b0;
    req        = '0;
    respReady  = 1'b1;
    switchIn   = 8'd0;
    enterA     = 1'b0;
    enterB     = 1'b0;
    testIn     = 3'($urandom % 8);
    stallMode  = 1'b0;
    latencyChk = 1'b1;
    acceptSeen = 1'b0;
    cycle      = '0;
    segHold    = 0;
    segDrops   = 0;
    blinkHigh  = 0;
    errors     = 0;
    mdlSwA     = 8'd0;
    mdlSwB     = 8'd0;
    mdlLed     = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);

    // Data memory, upper address bits alias onto the word index
    foreach (addrs[i]) begin
      addrs[i] = $urandom & 32'h7FFF_FFFC;
      addEntry(memIoPkg::opStore, addrs[i], $urandom, swKeep, 8'd0);
    end
    foreach (addrs[i]) addEntry(memIoPkg::opLoad, addrs[i], 32'd0, swKeep, 8'd0);
    addEntry(memIoPkg::opLoad, 32'h0000_0F00, 32'd0, swKeep, 8'd0);
    runTable();

    // Back-pressure with mixed traffic
    repeat (24) begin
      addEntry(memIoPkg::memOpE'($urandom % 2), addrs[$urandom % 6], $urandom, swKeep, 8'd0);
    end
    @(posedge clk);
    stallMode  = 1'b1;
    latencyChk = 1'b0;
    @(negedge clk);
    runTable();
    @(posedge clk);
    stallMode  = 1'b0;
    latencyChk = 1'b1;
    @(negedge clk);

    // Read-side I/O
    addEntry(memIoPkg::opStore, memIoPkg::ioLedAddr, $urandom, swKeep, 8'd0);
    addEntry(memIoPkg::opLoad, memIoPkg::ioLedAddr, 32'd0, swKeep, 8'd0);
    addEntry(memIoPkg::opLoad, memIoPkg::ioSwAAddr, 32'd0, swEnterA, 8'($urandom));
    addEntry(memIoPkg::opLoad, memIoPkg::ioSwBAddr, 32'd0, swEnterB, 8'($urandom));
    addEntry(memIoPkg::opLoad, memIoPkg::ioSwAAddr, 32'd0, swKeep, 8'd0);
    addEntry(memIoPkg::opLoad, memIoPkg::ioTestAddr, 32'd0, swKeep, 8'd0);
    addEntry(memIoPkg::opLoad, memIoPkg::ioSegAddr, 32'd0, swKeep, 8'd0);
    addEntry(memIoPkg::opLoad, memIoPkg::ioBlinkAddr, 32'd0, swKeep, 8'd0);
    addEntry(memIoPkg::opLoad, memIoPkg::ioBase + 32'h0C, 32'd0, swKeep, 8'd0);
    addEntry(memIoPkg::opLoad, 32'hFFFF_FFFC, 32'd0, swKeep, 8'd0);
    runTable();
    if (ledOut !== mdlLed) begin
      $display("mismatch at %0t: ledOut %h, expected %h", $time, ledOut, mdlLed);
      errors++;
    end

    // Blink timer
    checkBlink(32'd5);
    checkBlink(32'd0);
    checkBlink(32'd13);

    // Display queue, a few entries then an overflowing burst
    repeat (3) addEntry(memIoPkg::opStore, memIoPkg::ioSegAddr, $urandom, swKeep, 8'd0);
    runTable();
    // Burst starts while the first entries are still shown, so the tail finds it full
    repeat (34) addEntry(memIoPkg::opStore, memIoPkg::ioSegAddr, $urandom, swKeep, 8'd0);
    runTable();
    if (segDrops == 0) begin
      $display("Display queue never filled, no push was dropped");
      errors++;
    end
    waitSegEmpty();
    // One more edge to compare the blank display
    @(negedge clk);

    finishRun();
  end

endmodule

// File: verilog.f
src/memIoPkg.sv
src/accessDecode.sv
src/dataMem.sv
src/ioPorts.sv
src/segDisplayQueue.sv
src/responseStage.sv
src/memIoTop.sv
verif/memIoTb.sv
